// File: rtl/axi_pkg.sv
package axi_pkg;

  // Field widths of the kept AR and R channel signals
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned ADDR_WIDTH = 64;
  localparam int unsigned LEN_WIDTH  = 8;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned RESP_WIDTH = 2;

  typedef logic [ID_WIDTH-1:0]   axi_id_t;
  typedef logic [ADDR_WIDTH-1:0] axi_addr_t;

  // Beats in the burst minus one
  typedef logic [LEN_WIDTH-1:0]  axi_len_t;

  typedef logic [DATA_WIDTH-1:0] axi_data_t;
  typedef logic [RESP_WIDTH-1:0] axi_resp_t;

  // Response codes as encoded on rresp
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

// File: rtl/xbar_map_pkg.sv
package xbar_map_pkg;

  import axi_pkg::*;

  // Downstream ports of the crossbar
  localparam int unsigned NUM_MST_PORTS = 3;

  // Outstanding reads, also the depth of the ordering FIFO
  localparam int unsigned MAX_TRANS = 4;

  typedef logic [1:0] port_idx_t;

  // FIFO pointer and fill level
  typedef logic [$clog2(MAX_TRANS)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(MAX_TRANS+1)-1:0] fifo_cnt_t;

  // Inclusive address range per port, index equals port number
  localparam axi_addr_t RULE_START [NUM_MST_PORTS] = '{
    64'h0000_0000_4030_0000,
    64'h0000_0000_4010_0000,
    64'h0000_0000_4000_0000
  };

  localparam axi_addr_t RULE_END [NUM_MST_PORTS] = '{
    64'h0000_0000_4030_FFFF,
    64'h0000_0000_4012_FFFF,
    64'h0000_0000_4001_FFFF
  };

endpackage

// File: rtl/route_if.sv
`timescale 1ns/1ps

interface route_if import axi_pkg::*, xbar_map_pkg::*; ();

  logic      valid;
  logic      ready;

  // Target port of the read, or a local error response
  port_idx_t port;
  logic      dec_err;

  // Needed to build DECERR beats without a target
  axi_id_t   id;
  axi_len_t  len;

  modport producer (
    output valid, port, dec_err, id, len,
    input  ready
  );

  modport consumer (
    input  valid, port, dec_err, id, len,
    output ready
  );

endinterface

// File: rtl/ar_decoder.sv
`timescale 1ns/1ps

module ar_decoder import axi_pkg::*, xbar_map_pkg::*; (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  axi_id_t                       slv_ar_id_i,
  input  axi_addr_t                     slv_ar_addr_i,
  input  axi_len_t                      slv_ar_len_i,
  input  logic                          slv_ar_valid_i,
  output logic                          slv_ar_ready_o,
  output axi_id_t   [NUM_MST_PORTS-1:0] mst_ar_id_o,
  output axi_addr_t [NUM_MST_PORTS-1:0] mst_ar_addr_o,
  output axi_len_t  [NUM_MST_PORTS-1:0] mst_ar_len_o,
  output logic      [NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input  logic      [NUM_MST_PORTS-1:0] mst_ar_ready_i,
  route_if.producer                     push
);

  logic      rule_hit;
  port_idx_t rule_port;
  port_idx_t sel_port;
  logic      dec_err;
  logic      sel_ready;
  logic      lock_q;
  port_idx_t port_q;

  // Address decode, lowest matching rule wins
  always_comb begin
    rule_hit  = 1'b0;
    rule_port = '0;
    for (int i = NUM_MST_PORTS - 1; i >= 0; i--) begin
      if (slv_ar_addr_i >= RULE_START[i] && slv_ar_addr_i <= RULE_END[i]) begin
        rule_hit  = 1'b1;
        rule_port = port_idx_t'(i);
      end
    end
  end

  // A waiting downstream AR keeps the port it was offered to
  assign sel_port = lock_q ? port_q : rule_port;
  assign dec_err  = !lock_q && !rule_hit;

  always_comb begin
    sel_ready = 1'b0;
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_ar_id_o[i]    = slv_ar_id_i;
      mst_ar_addr_o[i]  = slv_ar_addr_i;
      mst_ar_len_o[i]   = slv_ar_len_i;
      // Only offered while the FIFO can take the routing entry
      mst_ar_valid_o[i] = slv_ar_valid_i && !dec_err && push.ready &&
                          (sel_port == port_idx_t'(i));
      if (sel_port == port_idx_t'(i)) begin
        sel_ready = mst_ar_ready_i[i];
      end
    end
  end

  // Upstream, downstream and FIFO handshakes coincide
  assign push.valid     = slv_ar_valid_i && (dec_err || sel_ready);
  assign push.port      = sel_port;
  assign push.dec_err   = dec_err;
  assign push.id        = slv_ar_id_i;
  assign push.len       = slv_ar_len_i;
  assign slv_ar_ready_o = push.ready && (dec_err || sel_ready);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      port_q <= '0;
    end else begin
      lock_q <= (|mst_ar_valid_o) && !sel_ready;
      port_q <= sel_port;
    end
  end

endmodule

// File: rtl/read_order_fifo.sv
`timescale 1ns/1ps

module read_order_fifo import axi_pkg::*, xbar_map_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  route_if.consumer push,
  route_if.producer head
);

  // Entry storage
  port_idx_t port_mem    [MAX_TRANS];
  logic      dec_err_mem [MAX_TRANS];
  axi_id_t   id_mem      [MAX_TRANS];
  axi_len_t  len_mem     [MAX_TRANS];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  fifo_cnt_t count_d;
  logic      ready_q;
  logic      push_fire;
  logic      pop_fire;

  assign push_fire = push.valid && push.ready;
  assign pop_fire  = head.valid && head.ready;

  assign count_d = count_q + fifo_cnt_t'(push_fire) - fifo_cnt_t'(pop_fire);

  // Registered room flag is low in the first cycle out of reset
  assign push.ready = ready_q;

  assign head.valid   = (count_q != '0);
  assign head.port    = port_mem[rd_ptr_q];
  assign head.dec_err = dec_err_mem[rd_ptr_q];
  assign head.id      = id_mem[rd_ptr_q];
  assign head.len     = len_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      port_mem[wr_ptr_q]    <= push.port;
      dec_err_mem[wr_ptr_q] <= push.dec_err;
      id_mem[wr_ptr_q]      <= push.id;
      len_mem[wr_ptr_q]     <= push.len;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ready_q  <= 1'b0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= (wr_ptr_q == fifo_ptr_t'(MAX_TRANS - 1)) ? '0 : wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop_fire) begin
        rd_ptr_q <= (rd_ptr_q == fifo_ptr_t'(MAX_TRANS - 1)) ? '0 : rd_ptr_q + fifo_ptr_t'(1);
      end
      count_q <= count_d;
      ready_q <= (count_d < fifo_cnt_t'(MAX_TRANS));
    end
  end

endmodule

// File: rtl/r_return_mux.sv
`timescale 1ns/1ps

module r_return_mux import axi_pkg::*, xbar_map_pkg::*; (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  route_if.consumer                     head,
  input  axi_id_t   [NUM_MST_PORTS-1:0] mst_r_id_i,
  input  axi_data_t [NUM_MST_PORTS-1:0] mst_r_data_i,
  input  axi_resp_t [NUM_MST_PORTS-1:0] mst_r_resp_i,
  input  logic      [NUM_MST_PORTS-1:0] mst_r_last_i,
  input  logic      [NUM_MST_PORTS-1:0] mst_r_valid_i,
  output logic      [NUM_MST_PORTS-1:0] mst_r_ready_o,
  output axi_id_t                       slv_r_id_o,
  output axi_data_t                     slv_r_data_o,
  output axi_resp_t                     slv_r_resp_o,
  output logic                          slv_r_last_o,
  output logic                          slv_r_valid_o,
  input  logic                          slv_r_ready_i
);

  typedef enum logic {
    IDLE,
    ERR_BEATS
  } err_state_e;

  err_state_e state_q;
  err_state_e state_d;
  axi_len_t   beat_q;
  axi_len_t   beat_d;
  logic       fwd_sel;

  // Head entry targets a real port
  assign fwd_sel = head.valid && !head.dec_err;

  always_comb begin
    slv_r_valid_o = 1'b0;
    slv_r_id_o    = '0;
    slv_r_data_o  = '0;
    slv_r_resp_o  = '0;
    slv_r_last_o  = 1'b0;
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_r_ready_o[i] = fwd_sel && slv_r_ready_i && (head.port == port_idx_t'(i));
      if (fwd_sel && head.port == port_idx_t'(i)) begin
        slv_r_valid_o = mst_r_valid_i[i];
        slv_r_id_o    = mst_r_id_i[i];
        slv_r_data_o  = mst_r_data_i[i];
        slv_r_resp_o  = mst_r_resp_i[i];
        slv_r_last_o  = mst_r_last_i[i];
      end
    end
    // Local error beats need no target
    if (state_q == ERR_BEATS) begin
      slv_r_valid_o = 1'b1;
      slv_r_id_o    = head.id;
      slv_r_data_o  = '0;
      slv_r_resp_o  = RESP_DECERR;
      slv_r_last_o  = (beat_q == head.len);
    end
  end

  // Entry leaves on the accepted last beat
  assign head.ready = slv_r_valid_o && slv_r_ready_i && slv_r_last_o;

  always_comb begin
    state_d = state_q;
    beat_d  = beat_q;
    case (state_q)
      IDLE: begin
        if (head.valid && head.dec_err) begin
          state_d = ERR_BEATS;
          beat_d  = '0;
        end
      end
      ERR_BEATS: begin
        if (slv_r_ready_i) begin
          if (beat_q == head.len) begin
            state_d = IDLE;
          end else begin
            beat_d = beat_q + axi_len_t'(1);
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
    end
  end

endmodule

// File: rtl/axi_read_xbar.sv
`timescale 1ns/1ps

module axi_read_xbar import axi_pkg::*, xbar_map_pkg::*; (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  // Upstream AR
  input  axi_id_t                       slv_ar_id_i,
  input  axi_addr_t                     slv_ar_addr_i,
  input  axi_len_t                      slv_ar_len_i,
  input  logic                          slv_ar_valid_i,
  output logic                          slv_ar_ready_o,
  // Upstream R
  output axi_id_t                       slv_r_id_o,
  output axi_data_t                     slv_r_data_o,
  output axi_resp_t                     slv_r_resp_o,
  output logic                          slv_r_last_o,
  output logic                          slv_r_valid_o,
  input  logic                          slv_r_ready_i,
  // Downstream AR
  output axi_id_t   [NUM_MST_PORTS-1:0] mst_ar_id_o,
  output axi_addr_t [NUM_MST_PORTS-1:0] mst_ar_addr_o,
  output axi_len_t  [NUM_MST_PORTS-1:0] mst_ar_len_o,
  output logic      [NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input  logic      [NUM_MST_PORTS-1:0] mst_ar_ready_i,
  // Downstream R
  input  axi_id_t   [NUM_MST_PORTS-1:0] mst_r_id_i,
  input  axi_data_t [NUM_MST_PORTS-1:0] mst_r_data_i,
  input  axi_resp_t [NUM_MST_PORTS-1:0] mst_r_resp_i,
  input  logic      [NUM_MST_PORTS-1:0] mst_r_last_i,
  input  logic      [NUM_MST_PORTS-1:0] mst_r_valid_i,
  output logic      [NUM_MST_PORTS-1:0] mst_r_ready_o
);

  // Decoder to FIFO, and FIFO head to return mux
  route_if push_if ();
  route_if head_if ();

  ar_decoder ar_decoder_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_len_i   (slv_ar_len_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .mst_ar_id_o    (mst_ar_id_o),
    .mst_ar_addr_o  (mst_ar_addr_o),
    .mst_ar_len_o   (mst_ar_len_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .push           (push_if.producer)
  );

  read_order_fifo read_order_fifo_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push     (push_if.consumer),
    .head     (head_if.producer)
  );

  r_return_mux r_return_mux_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head          (head_if.consumer),
    .mst_r_id_i    (mst_r_id_i),
    .mst_r_data_i  (mst_r_data_i),
    .mst_r_resp_i  (mst_r_resp_i),
    .mst_r_last_i  (mst_r_last_i),
    .mst_r_valid_i (mst_r_valid_i),
    .mst_r_ready_o (mst_r_ready_o),
    .slv_r_id_o    (slv_r_id_o),
    .slv_r_data_o  (slv_r_data_o),
    .slv_r_resp_o  (slv_r_resp_o),
    .slv_r_last_o  (slv_r_last_o),
    .slv_r_valid_o (slv_r_valid_o),
    .slv_r_ready_i (slv_r_ready_i)
  );

endmodule

// File: tb/tb_axi_read_xbar.sv
`timescale 1ns/1ps

module tb_axi_read_xbar import axi_pkg::*, xbar_map_pkg::*; ();

  localparam int NUM_TXN     = 48;
  localparam int HOLD_CYCLES = 60;
  localparam int MAX_CYCLES  = NUM_TXN * 200 + 1000;

  typedef logic [NUM_MST_PORTS-1:0] port_mask_t;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
    logic      dec_err;
  } req_t;

  logic                          clk_i;
  logic                          arst_n_i;
  axi_id_t                       slv_ar_id_i;
  axi_addr_t                     slv_ar_addr_i;
  axi_len_t                      slv_ar_len_i;
  logic                          slv_ar_valid_i;
  logic                          slv_ar_ready_o;
  axi_id_t                       slv_r_id_o;
  axi_data_t                     slv_r_data_o;
  axi_resp_t                     slv_r_resp_o;
  logic                          slv_r_last_o;
  logic                          slv_r_valid_o;
  logic                          slv_r_ready_i;
  axi_id_t   [NUM_MST_PORTS-1:0] mst_ar_id_o;
  axi_addr_t [NUM_MST_PORTS-1:0] mst_ar_addr_o;
  axi_len_t  [NUM_MST_PORTS-1:0] mst_ar_len_o;
  logic      [NUM_MST_PORTS-1:0] mst_ar_valid_o;
  logic      [NUM_MST_PORTS-1:0] mst_ar_ready_i;
  axi_id_t   [NUM_MST_PORTS-1:0] mst_r_id_i;
  axi_data_t [NUM_MST_PORTS-1:0] mst_r_data_i;
  axi_resp_t [NUM_MST_PORTS-1:0] mst_r_resp_i;
  logic      [NUM_MST_PORTS-1:0] mst_r_last_i;
  logic      [NUM_MST_PORTS-1:0] mst_r_valid_i;
  logic      [NUM_MST_PORTS-1:0] mst_r_ready_o;

  logic [31:0] lfsr_q;
  int          errors;
  int          cycles;
  int          issued;
  int          done_cnt;
  int          outstanding;
  logic        ar_pending;
  logic [1:0]  cur_cls;
  req_t        cur_ar;
  // Reference model holds one entry per accepted AR in acceptance order
  req_t        exp_q [$];
  axi_len_t    exp_beat;
  // Target models
  req_t        tgt_q [NUM_MST_PORTS][$];
  axi_len_t    tgt_beat [NUM_MST_PORTS];
  port_mask_t  tgt_valid;
  logic        stall_q;
  logic [38:0] stall_beat;

  axi_read_xbar axi_read_xbar_inst (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Address class 3 lies outside every range
  function automatic axi_addr_t range_base(input logic [1:0] cls);
    case (cls)
      2'd0:    return 64'h4030_0000;
      2'd1:    return 64'h4010_0000;
      2'd2:    return 64'h4000_0000;
      default: return 64'h5000_0000;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
    end
  endtask

  task automatic drive_inputs();
    if (!ar_pending && issued < NUM_TXN && take_bits(1) != 0) begin
      cur_cls        = 2'(take_bits(2));
      cur_ar.addr    = range_base(cur_cls) + 64'(take_bits(16));
      cur_ar.id      = axi_id_t'(take_bits(4));
      cur_ar.len     = axi_len_t'(take_bits(2));
      cur_ar.dec_err = (cur_cls == 2'd3);
      ar_pending     = 1'b1;
      issued++;
    end
    slv_ar_valid_i = ar_pending;
    slv_ar_id_i    = cur_ar.id;
    slv_ar_addr_i  = cur_ar.addr;
    slv_ar_len_i   = cur_ar.len;
    // Upstream takes about three beats in four
    slv_r_ready_i  = (take_bits(2) != 0);
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      mst_ar_ready_i[i] = (take_bits(1) != 0);
      // No R data at all during the opening hold phase
      if (!tgt_valid[i] && tgt_q[i].size() != 0 && cycles >= HOLD_CYCLES) begin
        tgt_valid[i] = (take_bits(1) != 0);
      end
      mst_r_valid_i[i] = tgt_valid[i];
      if (tgt_valid[i]) begin
        mst_r_id_i[i]   = tgt_q[i][0].id;
        mst_r_data_i[i] = 32'(tgt_q[i][0].addr) + 32'(tgt_beat[i]);
        mst_r_resp_i[i] = RESP_OKAY;
        mst_r_last_i[i] = (tgt_beat[i] == tgt_q[i][0].len);
      end
    end
  endtask

  task automatic observe_outputs();
    port_mask_t exp_mask;
    port_mask_t dn_fire;
    axi_data_t  exp_data;
    if (stall_q) begin
      check_val("slv_r_valid_o (stalled)", 64'(slv_r_valid_o), 64'd1);
      check_val("slv_r beat (stalled)",
                64'({slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o}), 64'(stall_beat));
    end
    exp_mask = (ar_pending && !cur_ar.dec_err) ? port_mask_t'(1 << cur_cls) : '0;
    check_val("mst_ar_valid_o", 64'(mst_ar_valid_o & ~exp_mask), 64'd0);
    dn_fire = mst_ar_valid_o & mst_ar_ready_i;
    for (int i = 0; i < NUM_MST_PORTS; i++) begin
      if (dn_fire[i]) begin
        tgt_q[i].push_back({mst_ar_id_o[i], mst_ar_addr_o[i], mst_ar_len_o[i], 1'b0});
      end
      if (mst_r_valid_i[i] && mst_r_ready_o[i]) begin
        tgt_valid[i] = 1'b0;
        if (tgt_beat[i] == tgt_q[i][0].len) begin
          tgt_q[i].delete(0);
          tgt_beat[i] = '0;
        end else begin
          tgt_beat[i] = tgt_beat[i] + 8'd1;
        end
      end
    end
    if (slv_ar_valid_i && slv_ar_ready_o) begin
      check_val("mst_ar handshake", 64'(dn_fire), 64'(exp_mask));
      if (!cur_ar.dec_err) begin
        check_val("mst_ar_id_o", 64'(mst_ar_id_o[cur_cls]), 64'(cur_ar.id));
        check_val("mst_ar_addr_o", mst_ar_addr_o[cur_cls], cur_ar.addr);
        check_val("mst_ar_len_o", 64'(mst_ar_len_o[cur_cls]), 64'(cur_ar.len));
      end
      exp_q.push_back(cur_ar);
      ar_pending = 1'b0;
      outstanding++;
    end else begin
      check_val("mst_ar handshake", 64'(dn_fire), 64'd0);
    end
    if (slv_r_valid_o && slv_r_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("R beat at %0t while no read is outstanding", $time);
      end else begin
        exp_data = exp_q[0].dec_err ? '0 : 32'(exp_q[0].addr) + 32'(exp_beat);
        check_val("slv_r_id_o", 64'(slv_r_id_o), 64'(exp_q[0].id));
        check_val("slv_r_data_o", 64'(slv_r_data_o), 64'(exp_data));
        check_val("slv_r_resp_o", 64'(slv_r_resp_o),
                  64'(exp_q[0].dec_err ? RESP_DECERR : RESP_OKAY));
        check_val("slv_r_last_o", 64'(slv_r_last_o), 64'(exp_beat == exp_q[0].len));
        if (exp_beat == exp_q[0].len) begin
          exp_q.delete(0);
          exp_beat = '0;
          outstanding--;
          done_cnt++;
        end else begin
          exp_beat = exp_beat + 8'd1;
        end
      end
    end
    stall_q    = slv_r_valid_o && !slv_r_ready_i;
    stall_beat = {slv_r_id_o, slv_r_data_o, slv_r_resp_o, slv_r_last_o};
    if (outstanding > int'(MAX_TRANS)) begin
      errors++;
      $display("%0d reads outstanding at %0t, limit is %0d", outstanding, $time, MAX_TRANS);
    end
  endtask

  initial begin
    lfsr_q         = 32'h3fd2_20c0;
    errors         = 0;
    cycles         = 0;
    issued         = 0;
    done_cnt       = 0;
    outstanding    = 0;
    ar_pending     = 1'b0;
    cur_cls        = '0;
    cur_ar         = '0;
    exp_beat       = '0;
    tgt_beat       = '{default: '0};
    tgt_valid      = '0;
    stall_q        = 1'b0;
    stall_beat     = '0;
    arst_n_i       = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = '0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = '0;
    mst_r_valid_i  = '0;
    repeat (10) @(posedge clk_i);
    #1;
    check_val("slv_r_valid_o", 64'(slv_r_valid_o), 64'd0);
    check_val("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'd0);
    arst_n_i = 1'b1;
    // Observe at the falling edge, drive just after the rising edge
    while (cycles < MAX_CYCLES &&
           !(issued == NUM_TXN && !ar_pending && exp_q.size() == 0)) begin
      @(negedge clk_i);
      observe_outputs();
      @(posedge clk_i);
      #1;
      drive_inputs();
      cycles++;
    end
    if (issued != NUM_TXN || ar_pending || exp_q.size() != 0) begin
      errors++;
      $display("Timeout after %0d cycles, %0d reads still expected", cycles, exp_q.size());
    end
    $display("Errors: %0d, reads completed: %0d of %0d", errors, done_cnt, NUM_TXN);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
rtl/axi_pkg.sv
rtl/xbar_map_pkg.sv
rtl/route_if.sv
rtl/ar_decoder.sv
rtl/read_order_fifo.sv
rtl/r_return_mux.sv
rtl/axi_read_xbar.sv
tb/tb_axi_read_xbar.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_axi_read_xbar \
  -f flist.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Result: PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
